//--- Bender.yml
package:
  name: fir

sources:
  - files:
      - design/fir_pkg.sv
      - design/fir_cfg_if.sv
      - design/fir_axil_regs.sv
      - design/fir_engine.sv
      - design/fir.sv
  - target: test
    files:
      - tests/fir_bram_model.sv
      - tests/fir_assertions.sv
      - tests/tb_fir.sv

//--- compile.f
design/fir_pkg.sv
design/fir_cfg_if.sv
design/fir_axil_regs.sv
design/fir_engine.sv
design/fir.sv
tests/fir_bram_model.sv
tests/fir_assertions.sv
tests/tb_fir.sv

//--- design/fir.sv
`timescale 1ns/100ps

module fir (
    // AXI-lite write
    output logic                 awready,
    output logic                 wready,
    input  logic                 awvalid,
    input  fir_pkg::addr_t       awaddr,
    input  logic                 wvalid,
    input  fir_pkg::data_t       wdata,
    // AXI-lite read
    output logic                 arready,
    input  logic                 rready,
    input  logic                 arvalid,
    input  fir_pkg::addr_t       araddr,
    output logic                 rvalid,
    output fir_pkg::data_t       rdata,
    // stream in
    input  logic                 ss_tvalid,
    input  fir_pkg::data_t       ss_tdata,
    output logic                 ss_tready,
    // stream out
    input  logic                 sm_tready,
    output logic                 sm_tvalid,
    output fir_pkg::data_t       sm_tdata,
    output logic                 sm_tlast,
    // tap RAM
    output logic [3:0]           tap_WE,
    output logic                 tap_EN,
    output fir_pkg::data_t       tap_Di,
    output fir_pkg::addr_t       tap_A,
    input  fir_pkg::data_t       tap_Do,
    // data RAM
    output logic [3:0]           data_WE,
    output logic                 data_EN,
    output fir_pkg::data_t       data_Di,
    output fir_pkg::addr_t       data_A,
    input  fir_pkg::data_t       data_Do,
    input  logic                 axis_clk,
    input  logic                 axis_rst_n
);

    fir_cfg_if cfg_if ();

    fir_axil_regs regs0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rready     (rready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .tap_WE     (tap_WE),
        .tap_EN     (tap_EN),
        .tap_Di     (tap_Di),
        .tap_A      (tap_A),
        .tap_Do     (tap_Do),
        .cfg        (cfg_if.regs)
    );

    // engine also sees tap_Do directly
    fir_engine engine0 (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .tap_Do     (tap_Do),
        .data_Do    (data_Do),
        .data_WE    (data_WE),
        .data_EN    (data_EN),
        .data_Di    (data_Di),
        .data_A     (data_A),
        .cfg        (cfg_if.engine)
    );

endmodule

//--- design/fir_axil_regs.sv
`timescale 1ns/100ps

module fir_axil_regs (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    // AXI-lite write address and data
    input  logic                 awvalid,
    input  fir_pkg::addr_t       awaddr,
    output logic                 awready,
    input  logic                 wvalid,
    input  fir_pkg::data_t       wdata,
    output logic                 wready,
    // AXI-lite read
    input  logic                 arvalid,
    input  fir_pkg::addr_t       araddr,
    output logic                 arready,
    input  logic                 rready,
    output logic                 rvalid,
    output fir_pkg::data_t       rdata,
    // tap RAM port
    output logic [3:0]           tap_WE,
    output logic                 tap_EN,
    output fir_pkg::data_t       tap_Di,
    output fir_pkg::addr_t       tap_A,
    input  fir_pkg::data_t       tap_Do,
    fir_cfg_if.regs              cfg
);

    typedef enum logic {WR_ADDR, WR_DATA} wr_state_t;
    typedef enum logic [1:0] {RD_ADDR, RD_BRAM, RD_CAPT, RD_RESP} rd_state_t;

    wr_state_t       wr_state;
    rd_state_t       rd_state;
    fir_pkg::addr_t  wr_addr;
    fir_pkg::addr_t  rd_addr;
    fir_pkg::data_t  data_length;
    logic            ap_done;
    logic            ap_idle;
    logic            rd_tap_ok;
    logic            wr_fire;
    logic            tap_wr;
    fir_pkg::data_t  rd_mux;

    function automatic logic is_tap(input fir_pkg::addr_t a);
        return (a >= fir_pkg::ADDR_TAP_BASE) && (a < fir_pkg::ADDR_TAP_END) && (a[1:0] == 2'b00);
    endfunction

    assign awready = (wr_state == WR_ADDR);
    assign wready  = (wr_state == WR_DATA);
    assign arready = (rd_state == RD_ADDR);
    assign rvalid  = (rd_state == RD_RESP);

    assign wr_fire = wvalid && wready;
    // tap writes land only while idle
    assign tap_wr  = wr_fire && ap_idle && is_tap(wr_addr);

    assign cfg.start = wr_fire && ap_idle && (wr_addr == fir_pkg::ADDR_AP_CTRL)
                       && wdata[fir_pkg::AP_START_BIT];
    assign cfg.data_length = data_length;

    // address then data, one after the other
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_state <= WR_ADDR;
            data_length <= '0;
        end else begin
            case (wr_state)
                WR_ADDR: if (awvalid) wr_state <= WR_DATA;
                WR_DATA: if (wvalid) wr_state <= WR_ADDR;
                default: wr_state <= WR_ADDR;
            endcase
            if (wr_fire && ap_idle && (wr_addr == fir_pkg::ADDR_DATA_LEN)) begin
                data_length <= wdata;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_idle <= 1'b1;
            ap_done <= 1'b0;
        end else begin
            if (cfg.start) begin
                ap_idle <= 1'b0;
            end else if (cfg.done_pulse) begin
                ap_idle <= 1'b1;
            end
            // done wins over a clearing read in the same cycle
            if (cfg.done_pulse) begin
                ap_done <= 1'b1;
            end else if (rvalid && rready && (rd_addr == fir_pkg::ADDR_AP_CTRL)) begin
                ap_done <= 1'b0;
            end
        end
    end

    // read FSM, two cycles from handshake to rvalid
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            rd_state <= RD_ADDR;
        end else begin
            case (rd_state)
                RD_ADDR: if (arvalid) rd_state <= RD_BRAM;
                // a tap write owns the port this cycle, so wait
                RD_BRAM: if (!tap_wr) rd_state <= RD_CAPT;
                RD_CAPT: rd_state <= RD_RESP;
                RD_RESP: if (rready) rd_state <= RD_ADDR;
                default: rd_state <= RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (awvalid && awready) begin
            wr_addr <= awaddr;
        end
        if (arvalid && arready) begin
            rd_addr <= araddr;
        end
        if (rd_state == RD_BRAM) begin
            rd_tap_ok <= !cfg.running;
        end
        if (rd_state == RD_CAPT) begin
            rdata <= rd_mux;
        end
    end

    always_comb begin
        rd_mux = '0;
        if (rd_addr == fir_pkg::ADDR_AP_CTRL) begin
            rd_mux[fir_pkg::AP_START_BIT] = cfg.running;
            rd_mux[fir_pkg::AP_DONE_BIT] = ap_done;
            rd_mux[fir_pkg::AP_IDLE_BIT] = ap_idle;
        end else if (rd_addr == fir_pkg::ADDR_DATA_LEN) begin
            rd_mux = data_length;
        end else if (is_tap(rd_addr) && rd_tap_ok) begin
            rd_mux = tap_Do;
        end
    end

    // tap RAM port: engine first, then AXI write, then AXI read
    always_comb begin
        tap_EN = 1'b0;
        tap_WE = 4'b0000;
        tap_A  = '0;
        tap_Di = wdata;
        if (cfg.running) begin
            tap_EN = cfg.tap_rd_en;
            tap_A  = cfg.tap_rd_addr;
        end else if (tap_wr) begin
            tap_EN = 1'b1;
            tap_WE = fir_pkg::WE_ALL;
            tap_A  = wr_addr - fir_pkg::ADDR_TAP_BASE;
        end else if ((rd_state == RD_BRAM) && is_tap(rd_addr)) begin
            tap_EN = 1'b1;
            tap_A  = rd_addr - fir_pkg::ADDR_TAP_BASE;
        end
    end

endmodule

//--- design/fir_cfg_if.sv
`timescale 1ns/100ps

interface fir_cfg_if;

    // register block to engine
    logic            start;
    fir_pkg::data_t  data_length;

    // engine to register block
    logic            running;
    logic            done_pulse;

    // engine tap reads, forwarded onto the tap RAM port
    logic            tap_rd_en;
    fir_pkg::addr_t  tap_rd_addr;

    modport regs (
        output start,
        output data_length,
        input  running,
        input  done_pulse,
        input  tap_rd_en,
        input  tap_rd_addr
    );

    modport engine (
        input  start,
        input  data_length,
        output running,
        output done_pulse,
        output tap_rd_en,
        output tap_rd_addr
    );

endinterface

//--- design/fir_engine.sv
`timescale 1ns/100ps

module fir_engine (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    // input sample stream
    input  logic                 ss_tvalid,
    input  fir_pkg::data_t       ss_tdata,
    output logic                 ss_tready,
    // output result stream
    input  logic                 sm_tready,
    output logic                 sm_tvalid,
    output fir_pkg::data_t       sm_tdata,
    output logic                 sm_tlast,
    // RAM read data
    input  fir_pkg::data_t       tap_Do,
    input  fir_pkg::data_t       data_Do,
    // data RAM port
    output logic [3:0]           data_WE,
    output logic                 data_EN,
    output fir_pkg::data_t       data_Di,
    output fir_pkg::addr_t       data_A,
    fir_cfg_if.engine            cfg
);

    fir_pkg::engine_state_t  state;
    fir_pkg::tap_idx_t       idx;
    fir_pkg::tap_idx_t       head;
    fir_pkg::tap_idx_t       rd_ptr;
    fir_pkg::data_t          out_count;
    fir_pkg::data_t          acc;
    fir_pkg::data_t          acc_sum;
    logic                    last_flag;
    logic                    mac_pending;
    logic                    rd_issue;
    logic                    mac_last;
    logic                    accept;
    logic                    out_fire;

    function automatic fir_pkg::addr_t word_addr(input fir_pkg::tap_idx_t i);
        return fir_pkg::addr_t'({i, 2'b00});
    endfunction

    assign ss_tready = (state == fir_pkg::WAIT_SAMPLE);
    assign sm_tvalid = (state == fir_pkg::OUTPUT);
    assign sm_tlast  = sm_tvalid && last_flag;

    assign accept   = ss_tvalid && ss_tready;
    assign out_fire = sm_tvalid && sm_tready;

    // one read per tap, idx 0..10
    assign rd_issue = (state == fir_pkg::MAC) && (idx < fir_pkg::NUM_TAPS);
    // product of the last read is on the RAM outputs
    assign mac_last = (state == fir_pkg::MAC) && (idx == fir_pkg::tap_idx_t'(fir_pkg::NUM_TAPS));

    // truncated to 32 bits
    assign acc_sum = acc + tap_Do * data_Do;

    assign cfg.running     = (state != fir_pkg::FINISH);
    assign cfg.done_pulse  = out_fire && last_flag;
    assign cfg.tap_rd_en   = rd_issue;
    assign cfg.tap_rd_addr = word_addr(idx);

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state       <= fir_pkg::FINISH;
            idx         <= '0;
            head        <= '0;
            rd_ptr      <= '0;
            out_count   <= '0;
            last_flag   <= 1'b0;
            mac_pending <= 1'b0;
        end else begin
            mac_pending <= rd_issue;
            case (state)
                fir_pkg::FINISH: begin
                    if (cfg.start) begin
                        state <= fir_pkg::CLEAR;
                        idx   <= '0;
                    end
                end
                fir_pkg::CLEAR: begin
                    if (idx == fir_pkg::LAST_TAP) begin
                        state     <= fir_pkg::WAIT_SAMPLE;
                        idx       <= '0;
                        head      <= '0;
                        out_count <= '0;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                fir_pkg::WAIT_SAMPLE: begin
                    if (accept) begin
                        state  <= fir_pkg::MAC;
                        idx    <= '0;
                        // newest sample first, walking back through history
                        rd_ptr <= head;
                        head   <= (head == fir_pkg::LAST_TAP) ? '0 : head + 1'b1;
                    end
                end
                fir_pkg::MAC: begin
                    if (rd_issue) begin
                        idx    <= idx + 1'b1;
                        rd_ptr <= (rd_ptr == '0) ? fir_pkg::LAST_TAP : rd_ptr - 1'b1;
                    end
                    if (mac_last) begin
                        state     <= fir_pkg::OUTPUT;
                        last_flag <= ((out_count + 1'b1) == cfg.data_length);
                    end
                end
                fir_pkg::OUTPUT: begin
                    if (out_fire) begin
                        out_count <= out_count + 1'b1;
                        state     <= last_flag ? fir_pkg::FINISH : fir_pkg::WAIT_SAMPLE;
                    end
                end
                default: state <= fir_pkg::FINISH;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            acc <= '0;
        end else if (mac_pending) begin
            acc <= acc_sum;
        end
        // held through back-pressure
        if (mac_last) begin
            sm_tdata <= acc_sum;
        end
    end

    // data RAM port
    always_comb begin
        data_EN = 1'b0;
        data_WE = 4'b0000;
        data_A  = '0;
        data_Di = ss_tdata;
        case (state)
            fir_pkg::CLEAR: begin
                data_EN = 1'b1;
                data_WE = fir_pkg::WE_ALL;
                data_A  = word_addr(idx);
                data_Di = '0;
            end
            fir_pkg::WAIT_SAMPLE: begin
                data_EN = accept;
                data_WE = accept ? fir_pkg::WE_ALL : 4'b0000;
                data_A  = word_addr(head);
            end
            fir_pkg::MAC: begin
                data_EN = rd_issue;
                data_A  = word_addr(rd_ptr);
            end
            default: begin
                data_EN = 1'b0;
            end
        endcase
    end

endmodule

//--- design/fir_pkg.sv
package fir_pkg;

    // bus and RAM widths
    typedef logic [11:0] addr_t;
    typedef logic [31:0] data_t;

    // index into the tap table and the history ring
    typedef logic [3:0] tap_idx_t;

    localparam int NUM_TAPS = 11;
    localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

    // byte enables for a full word write
    localparam logic [3:0] WE_ALL = 4'b1111;

    // register map
    localparam addr_t ADDR_AP_CTRL = 12'h000;
    localparam addr_t ADDR_DATA_LEN = 12'h010;
    localparam addr_t ADDR_TAP_BASE = 12'h020;
    localparam addr_t ADDR_TAP_END = ADDR_TAP_BASE + addr_t'(4 * NUM_TAPS);

    // bit positions inside ADDR_AP_CTRL
    localparam int AP_START_BIT = 0;
    localparam int AP_DONE_BIT = 1;
    localparam int AP_IDLE_BIT = 2;

    // FINISH doubles as the resting state between runs
    typedef enum logic [2:0] {
        CLEAR,
        WAIT_SAMPLE,
        MAC,
        OUTPUT,
        FINISH
    } engine_state_t;

endpackage

//--- tests/fir_assertions.sv
`timescale 1ns/100ps

module fir_assertions (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 awvalid,
    input  logic                 awready,
    input  fir_pkg::addr_t       awaddr,
    input  logic                 wvalid,
    input  logic                 wready,
    input  fir_pkg::data_t       wdata,
    input  logic                 ss_tvalid,
    input  logic                 sm_tvalid,
    input  logic                 sm_tready,
    input  fir_pkg::data_t       sm_tdata,
    input  logic                 sm_tlast,
    input  logic                 rvalid,
    input  logic                 rready,
    input  fir_pkg::data_t       rdata,
    input  logic                 ss_tready,
    input  logic [3:0]           tap_WE
);

    int fail_count = 0;

    // run and sample state seen from the ports only
    fir_pkg::addr_t  aw_addr_q;
    logic            busy;
    logic            in_flight;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            aw_addr_q <= '0;
            busy      <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_addr_q <= awaddr;
            end
            // a run lasts from the start write to the last output
            if (!busy && wvalid && wready && (aw_addr_q == fir_pkg::ADDR_AP_CTRL)
                && wdata[fir_pkg::AP_START_BIT]) begin
                busy <= 1'b1;
            end else if (sm_tvalid && sm_tready && sm_tlast) begin
                busy <= 1'b0;
            end
            if (ss_tvalid && ss_tready) begin
                in_flight <= 1'b1;
            end else if (sm_tvalid && sm_tready) begin
                in_flight <= 1'b0;
            end
        end
    end

    // result held under back-pressure
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (sm_tvalid && !sm_tready) |=> (sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)))
    else begin
        fail_count++;
        $error("sm_tdata or sm_tlast changed while waiting for sm_tready");
    end

    rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else begin
        fail_count++;
        $error("rdata changed while waiting for rready");
    end

    // one sample in flight
    one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(in_flight && ss_tready))
    else begin
        fail_count++;
        $error("ss_tready high while a result is pending");
    end

    tap_wr_idle: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        (tap_WE != 4'b0000) |-> !busy)
    else begin
        fail_count++;
        $error("tap RAM written while not idle");
    end

endmodule

bind fir fir_assertions asrt0 (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .ss_tvalid  (ss_tvalid),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .ss_tready  (ss_tready),
    .tap_WE     (tap_WE)
);

//--- tests/fir_bram_model.sv
`timescale 1ns/100ps

module fir_bram_model (
    input  logic                 clk,
    input  logic [3:0]           we,
    input  logic                 en,
    input  fir_pkg::data_t       wr_data,
    input  fir_pkg::addr_t       addr,
    output fir_pkg::data_t       rd_data
);

    fir_pkg::data_t mem [0:1023];

    // byte address in, word index from bits 11:2
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr[11:2]][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
            // old contents on a write, one cycle latency
            rd_data <= mem[addr[11:2]];
        end
    end

endmodule

//--- tests/tb_fir.sv
`timescale 1ns/100ps

module tb_fir;

    logic axis_clk;
    logic axis_rst_n = 1'b0;
    logic awvalid = 1'b0, wvalid = 1'b0, arvalid = 1'b0, rready = 1'b0;
    logic awready, wready, arready, rvalid;
    fir_pkg::addr_t awaddr = '0, araddr = '0;
    fir_pkg::data_t wdata = '0, ss_tdata = '0;
    fir_pkg::data_t rdata, sm_tdata, tap_Di, tap_Do, data_Di, data_Do;
    logic ss_tvalid = 1'b0, sm_tready = 1'b0;
    logic ss_tready, sm_tvalid, sm_tlast, tap_EN, data_EN;
    logic [3:0] tap_WE, data_WE;
    fir_pkg::addr_t tap_A, data_A;

    fir_pkg::data_t coef [fir_pkg::NUM_TAPS];
    int seed = 99;
    int errors = 0;
    int tests_run = 0;
    int max_wait_cycles = 200;

    fir dut0 (.*);

    fir_bram_model tap_ram0 (.clk(axis_clk), .we(tap_WE), .en(tap_EN), .wr_data(tap_Di),
                             .addr(tap_A), .rd_data(tap_Do));
    fir_bram_model data_ram0 (.clk(axis_clk), .we(data_WE), .en(data_EN), .wr_data(data_Di),
                              .addr(data_A), .rd_data(data_Do));

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    function automatic int total_errors();
        return errors + dut0.asrt0.fail_count;
    endfunction

    function automatic fir_pkg::addr_t tap_addr(input int i);
        return fir_pkg::ADDR_TAP_BASE + fir_pkg::addr_t'(4 * i);
    endfunction

    function automatic fir_pkg::data_t ctrl_word(input bit done, input bit idle);
        fir_pkg::data_t w;
        w = '0;
        w[fir_pkg::AP_DONE_BIT] = done;
        w[fir_pkg::AP_IDLE_BIT] = idle;
        return w;
    endfunction

    task automatic end_run();
        $display("tests run: %0d, errors: %0d", tests_run, total_errors());
        if (total_errors() == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // one cycle of a bounded wait, sampled at the falling edge
    task automatic tick(inout int n, input string what);
        n++;
        if (n > max_wait_cycles) begin
            $display("Timed out waiting for %s at %0t", what, $time);
            errors++;
            end_run();
        end else begin
            @(negedge axis_clk);
        end
    endtask

    task automatic check_value(input fir_pkg::data_t got, input fir_pkg::data_t exp,
                               input string what);
        assert (got === exp)
        else begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (total_errors() == errs_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errs_before);
    endtask

    task automatic axil_write(input fir_pkg::addr_t addr, input fir_pkg::data_t data);
        int n;
        n = 0;
        awvalid = 1'b1;
        awaddr = addr;
        @(negedge axis_clk);
        while (!awready) tick(n, "awready");
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b1;
        wdata = data;
        n = 0;
        @(negedge axis_clk);
        while (!wready) tick(n, "wready");
        @(posedge axis_clk);
        #1;
        wvalid = 1'b0;
    endtask

    task automatic axil_read(input fir_pkg::addr_t addr, output fir_pkg::data_t data);
        int n;
        n = 0;
        arvalid = 1'b1;
        araddr = addr;
        @(negedge axis_clk);
        while (!arready) tick(n, "arready");
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        n = 0;
        @(negedge axis_clk);
        while (!rvalid) tick(n, "rvalid");
        data = rdata;
        // hold rready low one cycle so rdata sits under back-pressure
        @(posedge axis_clk);
        #1;
        rready = 1'b1;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic send_sample(input fir_pkg::data_t x);
        int n;
        n = 0;
        ss_tvalid = 1'b1;
        ss_tdata = x;
        @(negedge axis_clk);
        while (!ss_tready) tick(n, "ss_tready");
        @(posedge axis_clk);
        #1;
        ss_tvalid = 1'b0;
    endtask

    task automatic take_result(input bit stall, output fir_pkg::data_t d, output logic last);
        int n;
        int hold;
        n = 0;
        sm_tready = !stall;
        @(negedge axis_clk);
        while (!sm_tvalid) tick(n, "sm_tvalid");
        if (stall) begin
            hold = 1 + ({$random(seed)} % 5);
            repeat (hold) @(posedge axis_clk);
            #1;
            sm_tready = 1'b1;
            @(negedge axis_clk);
        end
        d = sm_tdata;
        last = sm_tlast;
        @(posedge axis_clk);
        #1;
        sm_tready = 1'b0;
    endtask

    // zero history at start, products truncated to 32 bits
    task automatic run_stream(input int len, input bit stall, input bit poke_tap);
        fir_pkg::data_t hist[$];
        fir_pkg::data_t x, exp, got, rd;
        logic last;
        axil_write(fir_pkg::ADDR_DATA_LEN, fir_pkg::data_t'(len));
        // clears a stale ap_done
        axil_read(fir_pkg::ADDR_AP_CTRL, rd);
        axil_write(fir_pkg::ADDR_AP_CTRL, 32'h1);
        if (poke_tap)
            axil_write(tap_addr(0), ~coef[0]);
        for (int k = 0; k < len; k++) begin
            x = $random(seed);
            hist.push_front(x);
            exp = '0;
            for (int i = 0; i < fir_pkg::NUM_TAPS && i < hist.size(); i++)
                exp = exp + coef[i] * hist[i];
            send_sample(x);
            take_result(stall, got, last);
            check_value(got, exp, "sm_tdata");
            check_value(fir_pkg::data_t'(last), fir_pkg::data_t'(k == len - 1), "sm_tlast");
        end
    endtask

    initial begin
        fir_pkg::data_t rd;
        int errs;
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        errs = total_errors();
        axil_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_value(rd, ctrl_word(1'b0, 1'b1), "ap_ctrl after reset");
        finish_test("reset state", errs);

        errs = total_errors();
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            coef[i] = $random(seed);
            axil_write(tap_addr(i), coef[i]);
        end
        axil_write(fir_pkg::ADDR_DATA_LEN, 32'd7);
        axil_read(fir_pkg::ADDR_DATA_LEN, rd);
        check_value(rd, 32'd7, "data_length");
        // short run with a tap write landing while running
        run_stream(2, 1'b0, 1'b1);
        for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            axil_read(tap_addr(i), rd);
            check_value(rd, coef[i], "tap readback");
        end
        finish_test("register and tap readback", errs);

        errs = total_errors();
        run_stream(20, 1'b0, 1'b0);
        finish_test("stream without back-pressure", errs);

        errs = total_errors();
        run_stream(15, 1'b1, 1'b0);
        finish_test("stream with back-pressure", errs);

        errs = total_errors();
        run_stream(3, 1'b0, 1'b0);
        axil_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_value(rd, ctrl_word(1'b1, 1'b1), "ap_ctrl after last output");
        axil_read(fir_pkg::ADDR_AP_CTRL, rd);
        check_value(rd, ctrl_word(1'b0, 1'b1), "ap_ctrl on second read");
        finish_test("tlast and ap_done", errs);

        end_run();
    end

endmodule
